// File: dbg_cluster.f
dbg_cluster_pkg.sv
dport_ic.sv
hart_run_ctrl.sv
hart_dport.sv
dbg_cluster_top.sv
tb_dbg_cluster.sv

// File: dbg_cluster_pkg.sv
/* Debug cluster package: word, register index and hart index types,
   register map, error codes, status bits and the run-control state enum */
package dbg_cluster_pkg;

    // Bus widths
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 6;
    localparam int HART_IDX_W = 2;  // Limits the cluster to four harts

    typedef logic [DATA_W-1:0]     dport_word_t;  // Write and read data
    typedef logic [ADDR_W-1:0]     dport_addr_t;  // Register index
    typedef logic [HART_IDX_W-1:0] hart_idx_t;    // Hart selection

    // Register map
    // Indices 0..31 are the general registers, 32 is status, the rest unmapped
    localparam int          NUM_GPR    = 32;
    localparam dport_addr_t REG_STATUS = dport_addr_t'(32);

    // Error codes returned in read data
    localparam dport_word_t ERR_NOT_HALTED = dport_word_t'(1);
    localparam dport_word_t ERR_BAD_ADDR   = dport_word_t'(2);

    // Bit positions in the status word
    localparam int STAT_HALTED  = 0;
    localparam int STAT_RUNNING = 1;
    localparam int STAT_ARMED   = 2;  // Halt-after-reset armed

    // Hart run-control states
    typedef enum logic [1:0] {
        RUN       = 2'd0,
        HALTED    = 2'd1,
        RESETTING = 2'd2
    } run_state_t;

endpackage

// File: dbg_cluster_stimulus.txt
# test command hart addr(hex) data(hex) exp_error exp_rdata(hex) exp_halted(hex)
# for wait the data column is the number of cycles
1 halt      0 00 00000000 0 00000000 1
1 halt      2 00 00000000 0 00000000 5
1 resume    0 00 00000000 0 00000000 4
1 halt      1 00 00000000 0 00000000 6
2 write     2 05 cafe0002 0 00000000 6
2 write     1 05 12345678 0 00000000 6
2 write     1 00 deadbeef 0 00000000 6
2 read      1 05 00000000 0 12345678 6
2 read      1 00 00000000 0 00000000 6
2 read      2 05 00000000 0 cafe0002 6
3 halt      0 00 00000000 0 00000000 7
3 write     0 03 0badf00d 0 00000000 7
3 resume    0 00 00000000 0 00000000 6
3 write     0 03 11112222 1 00000001 6
3 halt      0 00 00000000 0 00000000 7
3 read      0 03 00000000 0 0badf00d 7
4 read      0 20 00000000 0 00000001 7
4 read      3 20 00000000 0 00000002 7
4 write     3 20 ffffffff 1 00000002 7
4 read      0 28 00000000 1 00000002 7
5 hartreset 3 00 00000000 0 00000000 7
5 wait      3 00 00000003 0 00000000 7
5 read      3 20 00000000 0 00000002 7
5 resethalt 2 00 00000000 0 00000000 7
5 hartreset 2 00 00000000 0 00000000 3
5 wait      2 00 00000002 0 00000000 3
5 wait      2 00 00000001 0 00000000 7
5 read      2 20 00000000 0 00000005 7
5 read      2 05 00000000 0 00000000 7
6 write     0 0a 00c0ffee 0 00000000 7
6 read      0 0a 00000000 0 00c0ffee 7
6 read      3 0a 00000000 1 00000001 7

// File: dbg_cluster_top.sv
/* Debug cluster top: interconnect plus per-hart run control and register targets */
`timescale 1ns/1ps

module dbg_cluster_top import dbg_cluster_pkg::*; #(
    parameter int NUM_HARTS    = 4,
    parameter int RESET_CYCLES = 3
) (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  hart_idx_t            i_hartsel,
    input  logic                 i_haltreq,
    input  logic                 i_resumereq,
    input  logic                 i_resethaltreq,
    input  logic                 i_hartreset,
    input  logic                 i_dport_req_valid,
    input  logic                 i_dport_write,
    input  dport_addr_t          i_dport_addr,
    input  dport_word_t          i_dport_wdata,
    output logic                 o_dport_req_ready,
    input  logic                 i_dport_resp_ready,
    output logic                 o_dport_resp_valid,
    output logic                 o_dport_resp_error,
    output dport_word_t          o_dport_rdata,
    output logic [NUM_HARTS-1:0] o_halted
);

    // Interconnect to harts
    logic        [NUM_HARTS-1:0] hart_haltreq;
    logic        [NUM_HARTS-1:0] hart_resumereq;
    logic        [NUM_HARTS-1:0] hart_resethaltreq;
    logic        [NUM_HARTS-1:0] hart_reset;
    logic        [NUM_HARTS-1:0] hart_req_valid;
    logic        [NUM_HARTS-1:0] hart_resp_ready;
    logic                        hart_write;
    dport_addr_t                 hart_addr;
    dport_word_t                 hart_wdata;
    // Harts to interconnect
    logic        [NUM_HARTS-1:0] hart_req_ready;
    logic        [NUM_HARTS-1:0] hart_resp_valid;
    logic        [NUM_HARTS-1:0] hart_resp_error;
    dport_word_t [NUM_HARTS-1:0] hart_rdata;
    // Run control to register target
    logic        [NUM_HARTS-1:0] hart_running;
    logic        [NUM_HARTS-1:0] hart_armed;
    logic        [NUM_HARTS-1:0] hart_clear_regs;

    dport_ic #(
        .NUM_HARTS (NUM_HARTS)
    ) i_dport_ic (
        .i_clk               (i_clk),
        .i_nrst              (i_nrst),
        .i_hartsel           (i_hartsel),
        .i_haltreq           (i_haltreq),
        .i_resumereq         (i_resumereq),
        .i_resethaltreq      (i_resethaltreq),
        .i_hartreset         (i_hartreset),
        .i_dport_req_valid   (i_dport_req_valid),
        .i_dport_write       (i_dport_write),
        .i_dport_addr        (i_dport_addr),
        .i_dport_wdata       (i_dport_wdata),
        .o_dport_req_ready   (o_dport_req_ready),
        .i_dport_resp_ready  (i_dport_resp_ready),
        .o_dport_resp_valid  (o_dport_resp_valid),
        .o_dport_resp_error  (o_dport_resp_error),
        .o_dport_rdata       (o_dport_rdata),
        .o_hart_haltreq      (hart_haltreq),
        .o_hart_resumereq    (hart_resumereq),
        .o_hart_resethaltreq (hart_resethaltreq),
        .o_hart_reset        (hart_reset),
        .o_hart_req_valid    (hart_req_valid),
        .o_hart_write        (hart_write),
        .o_hart_addr         (hart_addr),
        .o_hart_wdata        (hart_wdata),
        .o_hart_resp_ready   (hart_resp_ready),
        .i_hart_req_ready    (hart_req_ready),
        .i_hart_resp_valid   (hart_resp_valid),
        .i_hart_resp_error   (hart_resp_error),
        .i_hart_rdata        (hart_rdata)
    );

    for (genvar g = 0; g < NUM_HARTS; g++) begin : g_hart
        hart_run_ctrl #(
            .RESET_CYCLES (RESET_CYCLES)
        ) i_hart_run_ctrl (
            .i_clk             (i_clk),
            .i_nrst            (i_nrst),
            .i_haltreq         (hart_haltreq[g]),
            .i_resumereq       (hart_resumereq[g]),
            .i_resethaltreq    (hart_resethaltreq[g]),
            .i_hartreset       (hart_reset[g]),
            .o_halted          (o_halted[g]),
            .o_running         (hart_running[g]),
            .o_resethalt_armed (hart_armed[g]),
            .o_clear_regs      (hart_clear_regs[g])
        );

        hart_dport i_hart_dport (
            .i_clk             (i_clk),
            .i_nrst            (i_nrst),
            .i_req_valid       (hart_req_valid[g]),
            .i_write           (hart_write),
            .i_addr            (hart_addr),
            .i_wdata           (hart_wdata),
            .o_req_ready       (hart_req_ready[g]),
            .i_resp_ready      (hart_resp_ready[g]),
            .o_resp_valid      (hart_resp_valid[g]),
            .o_resp_error      (hart_resp_error[g]),
            .o_rdata           (hart_rdata[g]),
            .i_halted          (o_halted[g]),
            .i_running         (hart_running[g]),
            .i_resethalt_armed (hart_armed[g]),
            .i_clear_regs      (hart_clear_regs[g])
        );
    end

endmodule

// File: dport_ic.sv
/* DMI-to-hart debug-port interconnect with control fan-out, request routing,
   stored hart index for the response path and the single-access busy flag */
`timescale 1ns/1ps

module dport_ic import dbg_cluster_pkg::*; #(
    parameter int NUM_HARTS = 4
) (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    // DMI side
    input  hart_idx_t                         i_hartsel,
    input  logic                              i_haltreq,
    input  logic                              i_resumereq,
    input  logic                              i_resethaltreq,
    input  logic                              i_hartreset,
    input  logic                              i_dport_req_valid,
    input  logic                              i_dport_write,
    input  dport_addr_t                       i_dport_addr,
    input  dport_word_t                       i_dport_wdata,
    output logic                              o_dport_req_ready,
    input  logic                              i_dport_resp_ready,
    output logic                              o_dport_resp_valid,
    output logic                              o_dport_resp_error,
    output dport_word_t                       o_dport_rdata,
    // Hart side
    output logic        [NUM_HARTS-1:0]       o_hart_haltreq,
    output logic        [NUM_HARTS-1:0]       o_hart_resumereq,
    output logic        [NUM_HARTS-1:0]       o_hart_resethaltreq,
    output logic        [NUM_HARTS-1:0]       o_hart_reset,
    output logic        [NUM_HARTS-1:0]       o_hart_req_valid,
    output logic                              o_hart_write,
    output dport_addr_t                       o_hart_addr,
    output dport_word_t                       o_hart_wdata,
    output logic        [NUM_HARTS-1:0]       o_hart_resp_ready,
    input  logic        [NUM_HARTS-1:0]       i_hart_req_ready,
    input  logic        [NUM_HARTS-1:0]       i_hart_resp_valid,
    input  logic        [NUM_HARTS-1:0]       i_hart_resp_error,
    input  dport_word_t [NUM_HARTS-1:0]       i_hart_rdata
);

    logic [NUM_HARTS-1:0] sel_mask;   // One-hot of i_hartsel
    logic [NUM_HARTS-1:0] resp_mask;  // One-hot of the stored index
    hart_idx_t            hartsel_q;  // Hart that owns the pending access
    logic                 busy_q;
    logic                 req_accept;
    logic                 resp_taken;

    // Out-of-range selection gives an empty mask
    always_comb begin
        for (int i = 0; i < NUM_HARTS; i++) begin
            sel_mask[i]  = (i_hartsel == hart_idx_t'(i));
            resp_mask[i] = (hartsel_q == hart_idx_t'(i));
        end
    end

    // Controls go to the selected hart only
    assign o_hart_haltreq      = sel_mask & {NUM_HARTS{i_haltreq}};
    assign o_hart_resumereq    = sel_mask & {NUM_HARTS{i_resumereq}};
    assign o_hart_resethaltreq = sel_mask & {NUM_HARTS{i_resethaltreq}};
    assign o_hart_reset        = sel_mask & {NUM_HARTS{i_hartreset}};

    // No hart sees a request while another access is pending
    assign o_hart_req_valid = sel_mask & {NUM_HARTS{i_dport_req_valid & ~busy_q}};
    assign o_hart_write     = i_dport_write;
    assign o_hart_addr      = i_dport_addr;
    assign o_hart_wdata     = i_dport_wdata;

    assign o_dport_req_ready = (|(sel_mask & i_hart_req_ready)) & ~busy_q;
    assign o_hart_resp_ready = resp_mask & {NUM_HARTS{i_dport_resp_ready}};

    // Response from the stored hart
    always_comb begin
        o_dport_resp_valid = 1'b0;
        o_dport_resp_error = 1'b0;
        o_dport_rdata      = '0;
        for (int i = 0; i < NUM_HARTS; i++) begin
            if (resp_mask[i]) begin
                o_dport_resp_valid = i_hart_resp_valid[i];
                o_dport_resp_error = i_hart_resp_error[i];
                o_dport_rdata      = i_hart_rdata[i];
            end
        end
    end

    assign req_accept = i_dport_req_valid & o_dport_req_ready;
    assign resp_taken = o_dport_resp_valid & i_dport_resp_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            hartsel_q <= '0;
            busy_q    <= 1'b0;
        end else if (req_accept) begin
            hartsel_q <= i_hartsel;  // Response path follows this hart
            busy_q    <= 1'b1;
        end else if (resp_taken) begin
            busy_q    <= 1'b0;
        end
    end

    // While the owning hart still holds its access nothing new is accepted anywhere
    a_single_outstanding: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(|(resp_mask & i_hart_req_ready)) |-> !o_dport_req_ready)
        else $error("dport_ic: request ready while a response is pending");

endmodule

// File: hart_dport.sv
/* Per-hart debug register target: general registers, status register,
   access checks and a fixed-latency response path held under back-pressure */
`timescale 1ns/1ps

module hart_dport import dbg_cluster_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic        i_write,
    input  dport_addr_t i_addr,
    input  dport_word_t i_wdata,
    output logic        o_req_ready,
    input  logic        i_resp_ready,
    output logic        o_resp_valid,
    output logic        o_resp_error,
    output dport_word_t o_rdata,
    input  logic        i_halted,
    input  logic        i_running,
    input  logic        i_resethalt_armed,
    input  logic        i_clear_regs
);

    localparam int GPR_IDX_W = $clog2(NUM_GPR);

    dport_word_t gpr [1:NUM_GPR-1];  // Register 0 is hardwired to zero

    // Access stage
    logic           acc_valid_q;
    logic           acc_write_q;
    dport_addr_t    acc_addr_q;
    dport_word_t    acc_wdata_q;
    logic [GPR_IDX_W-1:0] acc_idx;
    // Check stage
    logic           chk_valid_q;
    logic           chk_error_q;
    dport_word_t    chk_data_q;
    // Response stage
    logic           resp_valid_q;
    logic           resp_error_q;
    dport_word_t    resp_rdata_q;

    logic           req_accept;
    logic           resp_taken;
    logic           chk_error;
    dport_word_t    chk_data;
    logic           gpr_we;
    dport_word_t    status_word;

    // One access at a time, from acceptance until the response is taken
    assign o_req_ready = !(acc_valid_q || chk_valid_q || resp_valid_q);
    assign req_accept  = i_req_valid && o_req_ready;
    assign resp_taken  = resp_valid_q && i_resp_ready;
    assign acc_idx     = acc_addr_q[GPR_IDX_W-1:0];

    always_comb begin
        status_word               = '0;
        status_word[STAT_HALTED]  = i_halted;
        status_word[STAT_RUNNING] = i_running;
        status_word[STAT_ARMED]   = i_resethalt_armed;
    end

    // Access checks
    always_comb begin
        chk_error = 1'b0;
        chk_data  = '0;       // Also the read data of a good write
        gpr_we    = 1'b0;
        if (acc_addr_q < REG_STATUS) begin
            if (!i_halted) begin
                chk_error = 1'b1;
                chk_data  = ERR_NOT_HALTED;
            end else if (acc_write_q) begin
                gpr_we = acc_valid_q && (acc_idx != '0);
            end else if (acc_idx != '0) begin
                chk_data = gpr[acc_idx];
            end
        end else if (acc_addr_q == REG_STATUS && !acc_write_q) begin
            chk_data = status_word;
        end else begin
            chk_error = 1'b1;  // Status write or unmapped index
            chk_data  = ERR_BAD_ADDR;
        end
    end

    // General registers
    always_ff @(posedge i_clk) begin
        if (i_clear_regs) begin
            for (int i = 1; i < NUM_GPR; i++) begin
                gpr[i] <= '0;
            end
        end else if (gpr_we) begin
            gpr[acc_idx] <= acc_wdata_q;
        end
    end

    // Pipeline control
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            acc_valid_q  <= 1'b0;
            chk_valid_q  <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            acc_valid_q <= req_accept;
            chk_valid_q <= acc_valid_q;
            if (chk_valid_q) begin
                resp_valid_q <= 1'b1;
            end else if (resp_taken) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    // Pipeline payload
    always_ff @(posedge i_clk) begin
        if (req_accept) begin
            acc_write_q <= i_write;
            acc_addr_q  <= i_addr;
            acc_wdata_q <= i_wdata;
        end
        if (acc_valid_q) begin
            chk_error_q <= chk_error;
            chk_data_q  <= chk_data;
        end
        if (chk_valid_q) begin
            resp_error_q <= chk_error_q;
            resp_rdata_q <= chk_data_q;
        end
    end

    assign o_resp_valid = resp_valid_q;
    assign o_resp_error = resp_error_q;
    assign o_rdata      = resp_rdata_q;

    a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_resp_valid && !i_resp_ready) |=>
            (o_resp_valid && $stable(o_rdata) && $stable(o_resp_error)))
        else $error("hart_dport: response changed before it was taken");

endmodule

// File: hart_run_ctrl.sv
/* Per-hart run control: halt, resume, timed hart reset and halt-after-reset */
`timescale 1ns/1ps

module hart_run_ctrl import dbg_cluster_pkg::*; #(
    parameter int RESET_CYCLES = 3
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_haltreq,
    input  logic i_resumereq,
    input  logic i_resethaltreq,
    input  logic i_hartreset,
    output logic o_halted,
    output logic o_running,
    output logic o_resethalt_armed,
    output logic o_clear_regs
);

    localparam int CNT_W = (RESET_CYCLES > 1) ? $clog2(RESET_CYCLES) : 1;

    run_state_t       state_q;
    run_state_t       state_d;
    logic [CNT_W-1:0] cnt_q;    // Remaining reset cycles minus one
    logic             armed_q;
    logic             clear_q;

    always_comb begin
        state_d = state_q;
        if (i_hartreset) begin
            state_d = RESETTING;  // Also restarts a reset in progress
        end else begin
            case (state_q)
                RUN: begin
                    if (i_haltreq) state_d = HALTED;
                end
                HALTED: begin
                    if (i_resumereq && !i_haltreq) state_d = RUN;
                end
                RESETTING: begin
                    // Halt requests are ignored while in reset
                    if (cnt_q == '0) state_d = armed_q ? HALTED : RUN;
                end
                default: state_d = RUN;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= RUN;
            cnt_q   <= '0;
            armed_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            state_q <= state_d;
            clear_q <= i_hartreset;  // First cycle of reset
            if (i_hartreset) begin
                cnt_q <= CNT_W'(RESET_CYCLES - 1);
            end else if (state_q == RESETTING && cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            if (i_resethaltreq) armed_q <= 1'b1;  // Sticky until cluster reset
        end
    end

    assign o_halted          = (state_q == HALTED);
    assign o_running         = (state_q == RUN);
    assign o_resethalt_armed = armed_q;
    assign o_clear_regs      = clear_q;

    a_armed_exit_halts: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state_q == RESETTING && armed_q) |=> (state_q != RUN))
        else $error("hart_run_ctrl: left reset running with halt-after-reset armed");

endmodule

// File: tb_dbg_cluster.sv
/* Testbench for the debug cluster: stimulus file reader, DMI request and response driver,
   latency, hold and back-pressure checks against the expected values in the file */
`timescale 1ns/1ps

module tb_dbg_cluster import dbg_cluster_pkg::*; ();

    localparam int  NUM_HARTS    = 4;
    localparam int  RESET_CYCLES = 3;
    localparam real CLK_PERIOD   = 4.0;
    localparam int  MAX_WAIT     = 16;  // Handshake limit in cycles

    logic                 i_clk;
    logic                 i_nrst;
    hart_idx_t            i_hartsel;
    logic                 i_haltreq;
    logic                 i_resumereq;
    logic                 i_resethaltreq;
    logic                 i_hartreset;
    logic                 i_dport_req_valid;
    logic                 i_dport_write;
    dport_addr_t          i_dport_addr;
    dport_word_t          i_dport_wdata;
    logic                 o_dport_req_ready;
    logic                 i_dport_resp_ready;
    logic                 o_dport_resp_valid;
    logic                 o_dport_resp_error;
    dport_word_t          o_dport_rdata;
    logic [NUM_HARTS-1:0] o_halted;

    string       cmd_lines[$];
    bit          cmds_loaded;
    logic [31:0] lfsr_q;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          cur_test;

    dbg_cluster_top #(
        .NUM_HARTS    (NUM_HARTS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_dbg_cluster_top (.*);

    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_delay(output int n);
        n = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            n = (n << 1) | lfsr_q[0];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input int num);
        if (num != 0) begin
            tests_run++;
            if (test_errors == 0) $display("Test %0d passed", num);
            else $display("Test %0d failed with %0d errors", num, test_errors);
        end
        test_errors = 0;
    endtask

    // One register access, entered and left on a falling edge
    task automatic dport_access(input logic write, input dport_addr_t addr,
                                input dport_word_t wdata, output logic ok,
                                output logic err, output dport_word_t rdata);
        int          cycles;
        int          hold;
        logic        accepted;
        logic        held_err;
        dport_word_t held_rdata;
        hart_idx_t   sel;
        ok    = 1'b0;
        err   = 1'b0;
        rdata = '0;
        sel   = i_hartsel;
        i_dport_write     = write;
        i_dport_addr      = addr;
        i_dport_wdata     = wdata;
        i_dport_req_valid = 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && cycles < MAX_WAIT) begin
            @(posedge i_clk);
            accepted = o_dport_req_ready;  // Transfers at this edge
            cycles++;
            @(negedge i_clk);
        end
        i_dport_req_valid = 1'b0;
        if (!accepted) begin
            report_error("request was never accepted");
            return;
        end
        cycles = 0;
        while (!o_dport_resp_valid && cycles < MAX_WAIT) begin
            @(posedge i_clk);
            cycles++;
            @(negedge i_clk);
        end
        if (!o_dport_resp_valid) begin
            report_error("no response arrived after the request was accepted");
            return;
        end
        if (cycles < 2) report_error("response came earlier than 2 cycles after acceptance");
        if (cycles > 2) report_error("response came later than 2 cycles after acceptance");
        held_err   = o_dport_resp_error;
        held_rdata = o_dport_rdata;
        pick_delay(hold);
        for (int k = 0; k < hold; k++) begin
            i_hartsel = hart_idx_t'(k);  // Try every hart while blocked
            @(posedge i_clk);
            if (o_dport_req_ready)
                report_error("request ready while a response is pending");
            if (!o_dport_resp_valid)
                report_mismatch("o_dport_resp_valid", 1, o_dport_resp_valid);
            if (o_dport_resp_error !== held_err)
                report_mismatch("o_dport_resp_error", held_err, o_dport_resp_error);
            if (o_dport_rdata !== held_rdata)
                report_mismatch("o_dport_rdata", held_rdata, o_dport_rdata);
            @(negedge i_clk);
        end
        i_hartsel          = sel;
        i_dport_resp_ready = 1'b1;
        @(posedge i_clk);
        if (o_dport_req_ready) report_error("request ready in the cycle the response is taken");
        ok    = o_dport_resp_valid;
        err   = o_dport_resp_error;
        rdata = o_dport_rdata;
        if (!ok) report_error("response valid dropped before it was taken");
        @(negedge i_clk);
        i_dport_resp_ready = 1'b0;
    endtask

    task automatic run_command(input string line);
        int                   tnum;
        int                   hart;
        logic [8*12-1:0]      cmd;
        dport_addr_t          addr;
        dport_word_t          data;
        logic                 exp_err;
        dport_word_t          exp_rdata;
        logic [NUM_HARTS-1:0] exp_halted;
        logic                 ok;
        logic                 err;
        dport_word_t          rdata;
        if ($sscanf(line, "%d %s %d %h %h %d %h %h", tnum, cmd, hart, addr, data,
                    exp_err, exp_rdata, exp_halted) != 8) begin
            report_error("unreadable line in the stimulus file");
            return;
        end
        if (tnum != cur_test) begin
            finish_test(cur_test);
            cur_test = tnum;
        end
        i_hartsel = hart_idx_t'(hart);
        case (cmd)
            "halt", "resume", "resethalt", "hartreset": begin
                i_haltreq      = (cmd == "halt");
                i_resumereq    = (cmd == "resume");
                i_resethaltreq = (cmd == "resethalt");
                i_hartreset    = (cmd == "hartreset");
                @(posedge i_clk);
                @(negedge i_clk);
                i_haltreq      = 1'b0;
                i_resumereq    = 1'b0;
                i_resethaltreq = 1'b0;
                i_hartreset    = 1'b0;
            end
            "wait": begin
                repeat (data) begin
                    @(posedge i_clk);
                    @(negedge i_clk);
                end
            end
            "write", "read": begin
                dport_access(cmd == "write", addr, data, ok, err, rdata);
                if (ok && err !== exp_err)
                    report_mismatch("o_dport_resp_error", exp_err, err);
                if (ok && rdata !== exp_rdata)
                    report_mismatch("o_dport_rdata", exp_rdata, rdata);
            end
            default: report_error("unknown command in the stimulus file");
        endcase
        if (o_halted !== exp_halted) report_mismatch("o_halted", exp_halted, o_halted);
    endtask

    initial begin
        int    fd;
        string line;
        i_nrst             = 1'b0;
        i_hartsel          = '0;
        i_haltreq          = 1'b0;
        i_resumereq        = 1'b0;
        i_resethaltreq     = 1'b0;
        i_hartreset        = 1'b0;
        i_dport_req_valid  = 1'b0;
        i_dport_write      = 1'b0;
        i_dport_addr       = '0;
        i_dport_wdata      = '0;
        i_dport_resp_ready = 1'b0;
        lfsr_q             = 32'h34cd;
        fd = $fopen("dbg_cluster_stimulus.txt", "r");
        if (fd == 0) begin
            report_error("cannot open dbg_cluster_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") cmd_lines.push_back(line);
            end
            $fclose(fd);
        end
        cmds_loaded = 1'b1;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;
        foreach (cmd_lines[n]) run_command(cmd_lines[n]);
        finish_test(cur_test);
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog, 40 cycles per command plus reset
    initial begin
        wait (cmds_loaded);
        #((cmd_lines.size() * 40 + 10) * CLK_PERIOD);
        $display("Error at %0d ns: timeout, the stimulus did not complete", $time);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
